//--- flow_switch_defines.svh
`ifndef FLOW_SWITCH_DEFINES_SVH
`define FLOW_SWITCH_DEFINES_SVH

// Word layout
// Two destination bits on top of four payload bits
`define WORD_W 6

// FIFO sizing
`define FIFO_DEPTH 16
// Fill count must reach FIFO_DEPTH itself
`define CNT_W 5

// Number of switch ports
`define NUM_CH 4

// APB bus widths
`define APB_AW 4
`define APB_DW 8

`endif

//--- flow_switch_pkg.sv
`include "flow_switch_defines.svh"

package flow_switch_pkg;

	// Routed view of a word
	typedef struct packed {
		logic [1:0] dest;
		logic [3:0] payload;
	} word_fields_t;

	// One word, stored raw by the FIFOs and decoded by the arbiter
	typedef union packed {
		logic [`WORD_W-1:0] raw;
		word_fields_t       fields;
	} word_u;

	// Per-FIFO flags
	typedef struct packed {
		logic full;
		logic empty;
		logic almost_full;
		logic almost_empty;
		logic error;
	} fifo_status_t;

	// APB request from the bus master
	typedef struct packed {
		logic               psel;
		logic               penable;
		logic               pwrite;
		logic [`APB_AW-1:0] paddr;
		logic [`APB_DW-1:0] pwdata;
	} apb_req_t;

	// APB response back to the master
	typedef struct packed {
		logic [`APB_DW-1:0] prdata;
		logic               pready;
		logic               pslverr;
	} apb_rsp_t;

	// Shared almost-full and almost-empty levels
	typedef struct packed {
		logic [`CNT_W-1:0] af;
		logic [`CNT_W-1:0] ae;
	} thresh_t;

endpackage

//--- fifo16.sv
`timescale 1ns/1ps
`include "flow_switch_defines.svh"

module fifo16 (
	input  logic                          clk,
	input  logic                          reset_L,
	input  logic                          i_wr,
	input  flow_switch_pkg::word_u        i_wr_data,
	input  logic                          i_rd,
	output flow_switch_pkg::word_u        o_rd_data,
	input  flow_switch_pkg::thresh_t      i_thresh,
	output flow_switch_pkg::fifo_status_t o_status
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);

	// Storage, raw view only
	logic [`WORD_W-1:0] mem [`FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [`CNT_W-1:0] fill;
	logic overrun;
	logic underrun;
	logic full;
	logic empty;
	logic wr_ok;
	logic rd_ok;

	// Pointer step with wrap at the last entry
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(`FIFO_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign full  = (fill == `CNT_W'(`FIFO_DEPTH));
	assign empty = (fill == '0);

	// A full FIFO still takes a write when a read frees a slot
	assign wr_ok = i_wr && (!full || i_rd);
	// Reads only succeed with data present
	assign rd_ok = i_rd && !empty;

	always_ff @(posedge clk) begin
		if (wr_ok)
			mem[wr_ptr] <= i_wr_data.raw;
	end

	// Head word, valid while a pop is requested
	assign o_rd_data.raw = mem[rd_ptr];

	// Write side
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			wr_ptr  <= '0;
			overrun <= 1'b0;
		end else if (i_wr) begin
			if (wr_ok) begin
				wr_ptr  <= next_ptr(wr_ptr);
				overrun <= 1'b0;
			end else begin
				// Word dropped on a full FIFO
				overrun <= 1'b1;
			end
		end
	end

	// Read side
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			rd_ptr   <= '0;
			underrun <= 1'b0;
		end else if (i_rd) begin
			if (rd_ok) begin
				rd_ptr   <= next_ptr(rd_ptr);
				underrun <= 1'b0;
			end else begin
				// Pop of an empty FIFO
				underrun <= 1'b1;
			end
		end
	end

	// Fill count from push, pop and the two boundary flags
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			fill <= '0;
		end else begin
			casez ({i_wr, i_rd, !full, !empty})
				4'b01?1: fill <= fill - 1'b1;
				4'b101?: fill <= fill + 1'b1;
				// Write into empty FIFO while the read fails
				4'b1110: fill <= fill + 1'b1;
				// Read and write together leave the count alone
				default: fill <= fill;
			endcase
		end
	end

	// Flags straight off the registered count
	assign o_status.full         = full;
	assign o_status.empty        = empty;
	assign o_status.almost_full  = (fill >= i_thresh.af);
	assign o_status.almost_empty = (fill <= i_thresh.ae);
	assign o_status.error        = overrun | underrun;

endmodule

//--- vc_arbiter.sv
`timescale 1ns/1ps
`include "flow_switch_defines.svh"

module vc_arbiter (
	input  logic                          clk,
	input  logic                          reset_L,
	input  logic                          i_enable,
	input  flow_switch_pkg::fifo_status_t i_in_status  [`NUM_CH],
	input  flow_switch_pkg::word_u        i_in_head    [`NUM_CH],
	input  flow_switch_pkg::fifo_status_t i_out_status [`NUM_CH],
	output logic [`NUM_CH-1:0]            o_in_pop,
	output logic [`NUM_CH-1:0]            o_out_wr,
	output flow_switch_pkg::word_u        o_out_data
);

	import flow_switch_pkg::*;

	localparam int SEL_W = $clog2(`NUM_CH);

	logic [`NUM_CH-1:0] eligible;
	logic [SEL_W-1:0]   last_q;
	logic [SEL_W-1:0]   grant_idx;
	logic               grant_vld;

	// Transfer stage, one-hot write strobe plus the word
	logic [`NUM_CH-1:0] xfer_wr_q;
	word_u              xfer_word_q;

	// Input has data and its head's destination has room
	always_comb begin
		for (int i = 0; i < `NUM_CH; i++) begin
			eligible[i] = i_enable && !i_in_status[i].empty &&
				!i_out_status[i_in_head[i].fields.dest].almost_full;
		end
	end

	// Rotating search starting just after the last grant
	always_comb begin
		logic [SEL_W-1:0] idx;
		grant_vld = 1'b0;
		grant_idx = last_q;
		idx       = last_q;
		for (int k = 1; k <= `NUM_CH; k++) begin
			idx = last_q + SEL_W'(k);
			if (!grant_vld && eligible[idx]) begin
				grant_vld = 1'b1;
				grant_idx = idx;
			end
		end
	end

	// Pop the granted input in the grant cycle
	always_comb begin
		o_in_pop = '0;
		if (grant_vld)
			o_in_pop[grant_idx] = 1'b1;
	end

	// Priority pointer and write strobes
	always_ff @(posedge clk) begin
		if (!reset_L) begin
			// Start so that input 0 is searched first
			last_q    <= SEL_W'(`NUM_CH - 1);
			xfer_wr_q <= '0;
		end else begin
			xfer_wr_q <= '0;
			if (grant_vld) begin
				last_q <= grant_idx;
				xfer_wr_q[i_in_head[grant_idx].fields.dest] <= 1'b1;
			end
		end
	end

	// Word captured alongside the strobe
	always_ff @(posedge clk) begin
		if (grant_vld)
			xfer_word_q <= i_in_head[grant_idx];
	end

	// Written into the destination FIFO one cycle after the grant
	assign o_out_wr   = xfer_wr_q;
	assign o_out_data = xfer_word_q;

endmodule

//--- flow_ctrl_regs.sv
`timescale 1ns/1ps
`include "flow_switch_defines.svh"

module flow_ctrl_regs (
	input  logic                          clk,
	input  logic                          reset_L,
	input  flow_switch_pkg::apb_req_t     i_apb,
	output flow_switch_pkg::apb_rsp_t     o_apb,
	input  flow_switch_pkg::fifo_status_t i_in_status  [`NUM_CH],
	input  flow_switch_pkg::fifo_status_t i_out_status [`NUM_CH],
	output logic                          o_enable,
	output flow_switch_pkg::thresh_t      o_thresh
);

	import flow_switch_pkg::*;

	// Width of one threshold nibble
	localparam int NIB_W = `APB_DW / 2;

	localparam logic [`APB_AW-1:0] ADDR_CTRL   = `APB_AW'('h0);
	localparam logic [`APB_AW-1:0] ADDR_THRESH = `APB_AW'('h4);
	localparam logic [`APB_AW-1:0] ADDR_STATUS = `APB_AW'('h8);
	localparam logic [`APB_AW-1:0] ADDR_ERR    = `APB_AW'('hC);

	logic               enable_q;
	thresh_t            thresh_q;
	logic [`APB_DW-1:0] err_q;
	logic [`APB_DW-1:0] err_set;
	logic [`APB_DW-1:0] err_clr;
	logic [`APB_DW-1:0] status;
	logic [`APB_DW-1:0] rd_mux;
	logic               access;
	logic               wr_en;
	logic               addr_ok;
	logic [NIB_W-1:0]   af_wr;

	// Access phase of an APB transfer
	assign access = i_apb.psel && i_apb.penable;
	assign wr_en  = access && i_apb.pwrite;

	assign addr_ok = (i_apb.paddr == ADDR_CTRL)   || (i_apb.paddr == ADDR_THRESH) ||
	                 (i_apb.paddr == ADDR_STATUS) || (i_apb.paddr == ADDR_ERR);

	// Almost-full of zero is raised to one
	assign af_wr = (i_apb.pwdata[NIB_W-1:0] == '0) ? NIB_W'(1) : i_apb.pwdata[NIB_W-1:0];

	// Empty flags and error sources, outputs low, inputs high
	always_comb begin
		for (int i = 0; i < `NUM_CH; i++) begin
			status[i]          = i_out_status[i].empty;
			status[i + NIB_W]  = i_in_status[i].empty;
			err_set[i]         = i_in_status[i].error;
			err_set[i + NIB_W] = i_out_status[i].error;
		end
	end

	// Write-one-to-clear mask
	assign err_clr = (wr_en && i_apb.paddr == ADDR_ERR) ? i_apb.pwdata : '0;

	always_ff @(posedge clk) begin
		if (!reset_L) begin
			enable_q    <= 1'b0;
			thresh_q.af <= `CNT_W'(15);
			thresh_q.ae <= `CNT_W'(1);
			err_q       <= '0;
		end else begin
			if (wr_en && i_apb.paddr == ADDR_CTRL)
				enable_q <= i_apb.pwdata[0];
			if (wr_en && i_apb.paddr == ADDR_THRESH) begin
				thresh_q.af <= `CNT_W'(af_wr);
				thresh_q.ae <= `CNT_W'(i_apb.pwdata[`APB_DW-1:NIB_W]);
			end
			// A new error beats a clear in the same cycle
			err_q <= (err_q & ~err_clr) | err_set;
		end
	end

	// Read mux, zero for unmapped addresses
	always_comb begin
		case (i_apb.paddr)
			ADDR_CTRL:   rd_mux = `APB_DW'(enable_q);
			ADDR_THRESH: rd_mux = {thresh_q.ae[NIB_W-1:0], thresh_q.af[NIB_W-1:0]};
			ADDR_STATUS: rd_mux = status;
			ADDR_ERR:    rd_mux = err_q;
			default:     rd_mux = '0;
		endcase
	end

	assign o_apb.prdata  = (i_apb.psel && !i_apb.pwrite) ? rd_mux : '0;
	// No wait states
	assign o_apb.pready  = 1'b1;
	assign o_apb.pslverr = access && !addr_ok;

	assign o_enable = enable_q;
	assign o_thresh = thresh_q;

endmodule

//--- flow_switch_top.sv
`timescale 1ns/1ps
`include "flow_switch_defines.svh"

module flow_switch_top (
	input  logic                      clk,
	input  logic                      reset_L,
	input  flow_switch_pkg::apb_req_t i_apb,
	output flow_switch_pkg::apb_rsp_t o_apb,
	input  logic [`NUM_CH-1:0]        i_push,
	input  flow_switch_pkg::word_u    i_in_data  [`NUM_CH],
	input  logic [`NUM_CH-1:0]        i_pop,
	output flow_switch_pkg::word_u    o_out_data [`NUM_CH],
	output logic [`NUM_CH-1:0]        o_out_empty
);

	import flow_switch_pkg::*;

	// Input side
	fifo_status_t in_status  [`NUM_CH];
	word_u        in_head    [`NUM_CH];
	logic [`NUM_CH-1:0] in_pop;

	// Output side
	fifo_status_t out_status [`NUM_CH];
	word_u        out_head   [`NUM_CH];
	logic [`NUM_CH-1:0] out_wr;

	// One word bus from the arbiter to all output FIFOs
	word_u   xfer_data;

	logic    enable;
	thresh_t thresh;

	for (genvar g = 0; g < `NUM_CH; g++) begin : g_ch

		// Filled by the port, drained by the arbiter
		fifo16 u_in_fifo (
			.clk       (clk),
			.reset_L   (reset_L),
			.i_wr      (i_push[g]),
			.i_wr_data (i_in_data[g]),
			.i_rd      (in_pop[g]),
			.o_rd_data (in_head[g]),
			.i_thresh  (thresh),
			.o_status  (in_status[g])
		);

		// Filled by the arbiter, drained by the consumer
		fifo16 u_out_fifo (
			.clk       (clk),
			.reset_L   (reset_L),
			.i_wr      (out_wr[g]),
			.i_wr_data (xfer_data),
			.i_rd      (i_pop[g]),
			.o_rd_data (out_head[g]),
			.i_thresh  (thresh),
			.o_status  (out_status[g])
		);

		// Port shows the head word only during a pop
		assign o_out_data[g]  = i_pop[g] ? out_head[g] : '0;
		assign o_out_empty[g] = out_status[g].empty;
	end

	vc_arbiter u_arbiter (
		.clk          (clk),
		.reset_L      (reset_L),
		.i_enable     (enable),
		.i_in_status  (in_status),
		.i_in_head    (in_head),
		.i_out_status (out_status),
		.o_in_pop     (in_pop),
		.o_out_wr     (out_wr),
		.o_out_data   (xfer_data)
	);

	flow_ctrl_regs u_regs (
		.clk          (clk),
		.reset_L      (reset_L),
		.i_apb        (i_apb),
		.o_apb        (o_apb),
		.i_in_status  (in_status),
		.i_out_status (out_status),
		.o_enable     (enable),
		.o_thresh     (thresh)
	);

endmodule

//--- tb_flow_switch.sv
`timescale 1ns/1ps
`include "flow_switch_defines.svh"

module tb_flow_switch;

	import flow_switch_pkg::*;

	// Cycle limits for the wait loops
	localparam int APB_TIMEOUT   = 16;
	localparam int DRAIN_TIMEOUT = 2000;
	localparam int POP_LIMIT     = 16;

	// Register map
	localparam logic [3:0] A_CTRL   = 4'h0;
	localparam logic [3:0] A_THRESH = 4'h4;
	localparam logic [3:0] A_STATUS = 4'h8;
	localparam logic [3:0] A_ERR    = 4'hC;

	logic               clk;
	logic               reset_L;
	apb_req_t           apb_req;
	apb_rsp_t           apb_rsp;
	logic [`NUM_CH-1:0] push;
	word_u              in_data   [`NUM_CH];
	logic [`NUM_CH-1:0] pop;
	word_u              out_data  [`NUM_CH];
	logic [`NUM_CH-1:0] out_empty;

	// One expected-word queue per source and destination pair
	logic [`WORD_W-1:0] exp_q [`NUM_CH*`NUM_CH][$];
	// Per-source sequence number carried in the payload
	logic [1:0]         seq   [`NUM_CH];

	int                 seed;
	int                 checks;
	int                 errors;
	int                 test_err;
	int                 pops_seen;
	bit                 auto_pop;
	logic [`WORD_W-1:0] exp_word;
	bit                 underflow;

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	flow_switch_top u_dut (
		.clk         (clk),
		.reset_L     (reset_L),
		.i_apb       (apb_req),
		.o_apb       (apb_rsp),
		.i_push      (push),
		.i_in_data   (in_data),
		.i_pop       (pop),
		.o_out_data  (out_data),
		.o_out_empty (out_empty)
	);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			test_err++;
			$display("FAIL t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(input string msg);
		errors++;
		test_err++;
		$display("%s", msg);
	endtask

	task automatic timeout_fail(input string what);
		$display("Timeout while %s at t=%0t", what, $time);
		$display("Testbench failed");
		$finish;
	endtask

	// Words still owed by the switch
	function automatic int total_expected();
		int sum;
		sum = 0;
		for (int q = 0; q < `NUM_CH * `NUM_CH; q++)
			sum += exp_q[q].size();
		return sum;
	endfunction

	// Source bits of the popped word pick the queue whose front is expected
	function automatic logic [`WORD_W-1:0] ref_expected(input int dst,
			input logic [`WORD_W-1:0] got, output bit empty_q);
		int idx;
		idx = int'(got[3:2]) * `NUM_CH + dst;
		empty_q = (exp_q[idx].size() == 0);
		if (empty_q)
			return '0;
		return exp_q[idx].pop_front();
	endfunction

	// Waits in the access phase until the slave is ready
	task automatic wait_ready(output logic [7:0] rdata, output logic slverr);
		int n;
		n = 0;
		#1;
		while (!apb_rsp.pready) begin
			if (n == APB_TIMEOUT)
				timeout_fail("waiting for pready");
			@(negedge clk);
			#1;
			n++;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		logic       slverr;
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b1;
		apb_req.paddr   = addr;
		apb_req.pwdata  = data;
		@(negedge clk);
		apb_req.penable = 1'b1;
		wait_ready(rdata, slverr);
		check($sformatf("o_apb.pslverr write 0x%0h", addr), slverr, 1'b0);
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic apb_read(input logic [3:0] addr, output logic [7:0] rdata,
			output logic slverr);
		@(negedge clk);
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite  = 1'b0;
		apb_req.paddr   = addr;
		apb_req.pwdata  = '0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		wait_ready(rdata, slverr);
		@(negedge clk);
		apb_req = '0;
	endtask

	task automatic read_expect(input logic [3:0] addr, input logic [7:0] exp_data,
			input logic exp_err);
		logic [7:0] rdata;
		logic       slverr;
		apb_read(addr, rdata, slverr);
		check($sformatf("o_apb.prdata 0x%0h", addr), rdata, exp_data);
		check($sformatf("o_apb.pslverr 0x%0h", addr), slverr, exp_err);
	endtask

	// One push cycle followed by one idle cycle
	// Outputs with data are popped in both cycles when auto_pop is set
	task automatic push_word(input int port, input logic [1:0] dest, input bit keep);
		word_u w;
		w.fields.dest    = dest;
		w.fields.payload = {port[1:0], seq[port]};
		seq[port]        = seq[port] + 2'd1;
		if (keep)
			exp_q[port * `NUM_CH + dest].push_back(w.raw);
		@(negedge clk);
		push[port]    = 1'b1;
		in_data[port] = w;
		pop           = auto_pop ? ~out_empty : '0;
		@(negedge clk);
		push = '0;
		pop  = auto_pop ? ~out_empty : '0;
	endtask

	task automatic pop_word(input int port);
		@(negedge clk);
		pop[port] = 1'b1;
		@(negedge clk);
		pop[port] = 1'b0;
	endtask

	// Pops every non-empty output until nothing is owed
	task automatic drain_outputs();
		int n;
		n = 0;
		while (total_expected() != 0) begin
			if (n == DRAIN_TIMEOUT)
				timeout_fail("draining the output FIFOs");
			@(negedge clk);
			pop = ~out_empty;
			n++;
		end
		@(negedge clk);
		pop = '0;
	endtask

	task automatic end_test(input int num, input string name);
		if (test_err == 0)
			$display("Test %0d %s: ok", num, name);
		else
			$display("Test %0d %s: %0d errors", num, name, test_err);
		test_err = 0;
	endtask

	// Checks each output port in the middle of the low phase
	// An output that is not popped must show zero
	always begin : compare_pops
		@(negedge clk);
		#1;
		for (int j = 0; j < `NUM_CH; j++) begin
			if (pop[j] && !out_empty[j]) begin
				exp_word = ref_expected(j, out_data[j].raw, underflow);
				pops_seen++;
				if (underflow)
					report_error($sformatf("Output %0d gave word %0h that no source sent",
						j, out_data[j].raw));
				else
					check($sformatf("o_out_data[%0d]", j), out_data[j].raw, exp_word);
			end else if (!pop[j]) begin
				check($sformatf("o_out_data[%0d] idle", j), out_data[j].raw, '0);
			end
		end
	end

	initial begin : main
		int         r;
		int         port;
		int         base;
		int         cnt;
		logic [3:0] used;
		seed      = 32'hfdf0_5142;
		reset_L   = 1'b0;
		apb_req   = '0;
		push      = '0;
		pop       = '0;
		auto_pop  = 1'b0;
		checks    = 0;
		errors    = 0;
		test_err  = 0;
		pops_seen = 0;
		for (int i = 0; i < `NUM_CH; i++) begin
			in_data[i] = '0;
			seq[i]     = 2'd0;
		end
		repeat (10) @(negedge clk);
		reset_L = 1'b1;

		// Reset values, threshold clamp and unmapped addresses
		read_expect(A_CTRL, 8'h00, 1'b0);
		read_expect(A_THRESH, 8'h1F, 1'b0);
		read_expect(A_STATUS, 8'hFF, 1'b0);
		read_expect(A_ERR, 8'h00, 1'b0);
		apb_write(A_THRESH, 8'h3A);
		read_expect(A_THRESH, 8'h3A, 1'b0);
		apb_write(A_THRESH, 8'h20);
		read_expect(A_THRESH, 8'h21, 1'b0);
		read_expect(4'h2, 8'h00, 1'b1);
		read_expect(4'hE, 8'h00, 1'b1);
		apb_write(A_THRESH, 8'h1F);
		end_test(1, "registers");

		// Random ports and destinations with outputs popped as words land
		apb_write(A_CTRL, 8'h01);
		auto_pop = 1'b1;
		base     = pops_seen;
		repeat (64) begin
			r    = $random(seed);
			port = r & 3;
			push_word(port, r[3:2], 1'b1);
		end
		auto_pop = 1'b0;
		drain_outputs();
		check("routed word count", pops_seen - base, 64);
		read_expect(A_STATUS, 8'hFF, 1'b0);
		end_test(2, "routing");

		// Words wait in the input FIFOs while disabled
		apb_write(A_CTRL, 8'h00);
		base = pops_seen;
		used = '0;
		repeat (8) begin
			r          = $random(seed);
			port       = r & 3;
			used[port] = 1'b1;
			push_word(port, r[3:2], 1'b1);
		end
		// Longer than the two-cycle transfer latency
		repeat (4) @(negedge clk);
		read_expect(A_STATUS, {~used, 4'hF}, 1'b0);
		apb_write(A_CTRL, 8'h01);
		drain_outputs();
		check("drained word count", pops_seen - base, 8);
		end_test(3, "disable");

		// Almost-full of 4 on output 0 with no consumer
		apb_write(A_THRESH, 8'h14);
		base = pops_seen;
		for (int i = 0; i < 10; i++)
			push_word(1, 2'd0, 1'b1);
		repeat (8) @(negedge clk);
		// Freeze the arbiter so the held words can be counted
		apb_write(A_CTRL, 8'h00);
		cnt = 0;
		while (!out_empty[0]) begin
			if (cnt == POP_LIMIT)
				timeout_fail("popping output 0 until empty");
			pop_word(0);
			cnt++;
		end
		if (cnt < 4 || cnt > 5)
			report_error($sformatf("Output 0 held %0d words under back-pressure, not 4 or 5",
				cnt));
		// Input 1 still holds the blocked words
		read_expect(A_STATUS, 8'hDF, 1'b0);
		apb_write(A_THRESH, 8'h1F);
		apb_write(A_CTRL, 8'h01);
		drain_outputs();
		check("back-pressure word count", pops_seen - base, 10);
		end_test(4, "back-pressure");

		// Underrun on output 1 and overrun on input 2
		apb_write(A_CTRL, 8'h00);
		read_expect(A_ERR, 8'h00, 1'b0);
		pop_word(1);
		read_expect(A_ERR, 8'h20, 1'b0);
		for (int i = 0; i < 17; i++)
			push_word(2, 2'd1, i < 16);
		read_expect(A_ERR, 8'h24, 1'b0);
		apb_write(A_CTRL, 8'h01);
		drain_outputs();
		// An accepted push clears the input overrun flag
		push_word(2, 2'd1, 1'b1);
		drain_outputs();
		apb_write(A_ERR, 8'hFF);
		read_expect(A_ERR, 8'h00, 1'b0);
		end_test(5, "errors");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- flow_switch.f
+incdir+.
flow_switch_pkg.sv
fifo16.sv
vc_arbiter.sv
flow_ctrl_regs.sv
flow_switch_top.sv
tb_flow_switch.sv

//--- run_sim.sh
#!/bin/sh
# Builds the flow switch testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_flow_switch

verilator --binary --timing -Wno-fatal --top-module tb_flow_switch \
	-f flow_switch.f --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

# Result comes from the simulation log
if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
exit 0
